//--- verilog/sdram_cmd_cfg.svh
/* Sizing macros for the SDRAM command front end.
   Included by the packages, the RTL and the checker that need queue or burst sizes. */
`ifndef SDRAM_CMD_CFG_SVH
`define SDRAM_CMD_CFG_SVH

// Command queue entries
`define CMD_FIFO_DEPTH 16

// Single read results
`define WORD_FIFO_DEPTH 8

// Packed burst results
`define BURST_FIFO_DEPTH 4

// Almost full when this many slots or fewer remain
`define FIFO_ALM_MARGIN 2

// Words per burst read
`define BURST_LEN 8

`endif

//--- verilog/sync_fifo.sv
/* Show-ahead synchronous FIFO with a type parameter for the payload.
   The head is valid while empty_o is low; a push shows at the head one cycle later. */
`timescale 1ns/10ps
`default_nettype none
`include "sdram_cmd_cfg.svh"

module sync_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 8              // Power of two, pointers wrap
) (
    input  wire logic     sdram_clk,
    input  wire logic     sdram_rst,

    input  wire payload_t d_i,
    input  wire logic     enq_i,
    output logic          full_o,
    output logic          alm_full_o,

    output payload_t      q_o,
    input  wire logic     deq_i,
    output logic          empty_o
);
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    // Push when full and pop when empty are dropped
    assign push = enq_i && !full_o;
    assign pop  = deq_i && !empty_o;

    always_ff @(posedge sdram_clk) begin
        if (sdram_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge sdram_clk) begin
        if (push)
            mem[wr_ptr] <= d_i;
    end

    assign q_o        = mem[rd_ptr];
    assign full_o     = (count == CW'(DEPTH));
    assign alm_full_o = (count >= CW'(DEPTH - `FIFO_ALM_MARGIN));
    assign empty_o    = (count == '0);

endmodule

`default_nettype wire

//--- verilog/sdram_cmd_pkg.sv
/* Command, operation and result types shared by the front end stages.
   Modules import it in their body and use scoped names in their port lists. */
`default_nettype none
`include "sdram_cmd_cfg.svh"

package sdram_cmd_pkg;

    typedef logic [15:0] word_t;

    // Client command, write flag on top as bit 40
    typedef struct packed {
        logic        we;
        logic [23:0] addr;
        word_t       param;
    } cmd_t;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ_WORD,
        OP_READ_BURST
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [23:0] addr;
        word_t       data;     // Write data, unused on reads
    } op_t;

    // Slot 0 is the first word and sits in the top bits
    typedef word_t [0:`BURST_LEN-1] burst_t;

    typedef struct packed {
        word_t data;
        logic  last;           // Final word of the operation
        logic  burst;
    } rd_word_t;

endpackage

`default_nettype wire

//--- verilog/sdram_bus_pkg.sv
/* Wishbone classic request and response types between the execute stage
   and the SDRAM controller. */
`default_nettype none

package sdram_bus_pkg;

    typedef logic [23:0] wb_adr_t;   // Word address
    typedef logic [15:0] wb_dat_t;
    typedef logic [1:0]  wb_sel_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
        wb_sel_t sel;
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat;                // Read data, valid with ack
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- verilog/cmd_decode.sv
/* Pops the command queue and holds one decoded operation for the execute stage.
   A command reaches op_valid_o two cycles after the queue head turns valid. */
`timescale 1ns/10ps
`default_nettype none

module cmd_decode (
    input  wire logic                sdram_clk,
    input  wire logic                sdram_rst,

    input  wire sdram_cmd_pkg::cmd_t cmd_q_i,
    input  wire logic                cmd_empty_i,
    output logic                     cmd_deq_o,

    output sdram_cmd_pkg::op_t       op_o,
    output logic                     op_valid_o,
    input  wire logic                op_ready_i
);
    import sdram_cmd_pkg::*;

    logic slot_free;
    op_e  op_kind;

    // Output register empty now, or emptied by execute this cycle
    assign slot_free = !op_valid_o || op_ready_i;

    always_comb begin
        if (cmd_q_i.we)
            op_kind = OP_WRITE;
        else if (cmd_q_i.param[0])
            op_kind = OP_READ_BURST;
        else
            op_kind = OP_READ_WORD;
    end

    always_ff @(posedge sdram_clk) begin
        if (sdram_rst) begin
            cmd_deq_o  <= 1'b0;
            op_valid_o <= 1'b0;
        end else begin
            // One pop at a time, the head stays put until it lands
            cmd_deq_o <= !cmd_deq_o && !cmd_empty_i && slot_free;
            if (cmd_deq_o)
                op_valid_o <= 1'b1;
            else if (op_ready_i)
                op_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge sdram_clk) begin
        if (cmd_deq_o)
            op_o <= '{op: op_kind, addr: cmd_q_i.addr, data: cmd_q_i.param};
    end

endmodule

`default_nettype wire

//--- verilog/mem_execute.sv
/* Wishbone classic master running writes, single reads and eight beat burst reads.
   Reads start only while the result stage is ready, and each read beat leaves on rd_o. */
`timescale 1ns/10ps
`default_nettype none
`include "sdram_cmd_cfg.svh"

module mem_execute (
    input  wire logic                    sdram_clk,
    input  wire logic                    sdram_rst,

    input  wire sdram_cmd_pkg::op_t      op_i,
    input  wire logic                    op_valid_i,
    output logic                         op_ready_o,

    input  wire logic                    res_ready_i,
    output sdram_cmd_pkg::rd_word_t      rd_o,
    output logic                         rd_valid_o,

    output sdram_bus_pkg::wb_req_t       wb_o,
    input  wire sdram_bus_pkg::wb_rsp_t  wb_i
);
    import sdram_cmd_pkg::*;
    import sdram_bus_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_BEAT,       // Burst beat waiting for ack
        ST_GAP         // Strobe low between beats
    } state_e;

    localparam int            BW        = $clog2(`BURST_LEN);
    localparam logic [BW-1:0] LAST_BEAT = BW'(`BURST_LEN - 1);

    state_e        state;
    logic [BW-1:0] beat;
    logic          last_beat;
    logic          cyc_q;
    logic          stb_q;
    logic          we_q;
    wb_adr_t       adr_q;
    wb_dat_t       dat_q;

    // Writes never wait on the result side
    assign op_ready_o = (state == ST_IDLE) && op_valid_i &&
                        (op_i.op == OP_WRITE || res_ready_i);
    assign last_beat  = (beat == LAST_BEAT);

    always_ff @(posedge sdram_clk) begin
        if (sdram_rst) begin
            state      <= ST_IDLE;
            beat       <= '0;
            cyc_q      <= 1'b0;
            stb_q      <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (op_ready_o) begin
                        cyc_q <= 1'b1;
                        stb_q <= 1'b1;
                        beat  <= '0;
                        case (op_i.op)
                            OP_WRITE:     state <= ST_WRITE;
                            OP_READ_WORD: state <= ST_READ;
                            default:      state <= ST_BEAT;
                        endcase
                    end
                end
                ST_WRITE, ST_READ: begin
                    if (wb_i.ack) begin
                        cyc_q      <= 1'b0;
                        stb_q      <= 1'b0;
                        rd_valid_o <= (state == ST_READ);
                        state      <= ST_IDLE;
                    end
                end
                ST_BEAT: begin
                    if (wb_i.ack) begin
                        stb_q      <= 1'b0;
                        rd_valid_o <= 1'b1;
                        if (last_beat) begin
                            cyc_q <= 1'b0;  // Bus released after the eighth ack
                            state <= ST_IDLE;
                        end else begin
                            beat  <= beat + 1'b1;
                            state <= ST_GAP;
                        end
                    end
                end
                ST_GAP: begin
                    stb_q <= 1'b1;
                    state <= ST_BEAT;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Transfer fields and read capture
    always_ff @(posedge sdram_clk) begin
        if (op_ready_o) begin
            we_q  <= (op_i.op == OP_WRITE);
            adr_q <= op_i.addr;
            dat_q <= op_i.data;
        end else if (state == ST_BEAT && wb_i.ack && !last_beat) begin
            adr_q <= adr_q + 1'b1;  // Wraps at 2^24
        end
        if (wb_i.ack && (state == ST_READ || state == ST_BEAT)) begin
            rd_o.data  <= wb_i.dat;
            rd_o.last  <= (state == ST_READ) || last_beat;
            rd_o.burst <= (state == ST_BEAT);
        end
    end

    always_comb begin
        wb_o.cyc = cyc_q;
        wb_o.stb = stb_q;
        wb_o.we  = we_q;
        wb_o.adr = adr_q;
        wb_o.dat = dat_q;
        wb_o.sel = '1;      // Always both bytes
    end

endmodule

`default_nettype wire

//--- verilog/read_result.sv
/* Collects read words from the execute stage and pushes them into the result queues.
   Burst words shift into a packing register, first word toward the top. */
`timescale 1ns/10ps
`default_nettype none
`include "sdram_cmd_cfg.svh"

module read_result (
    input  wire logic                     sdram_clk,
    input  wire logic                     sdram_rst,

    input  wire sdram_cmd_pkg::rd_word_t  rd_i,
    input  wire logic                     rd_valid_i,
    output logic                          res_ready_o,

    input  wire logic                     word_full_i,
    input  wire logic                     burst_full_i,
    output sdram_cmd_pkg::word_t          word_d_o,
    output logic                          word_enq_o,
    output sdram_cmd_pkg::burst_t         burst_d_o,
    output logic                          burst_enq_o
);
    import sdram_cmd_pkg::*;

    burst_t pack;
    logic   packing;       // Burst partly collected

    // Queue flags lag a push by one cycle, so stay low from the
    // returning word until the count has caught up
    assign res_ready_o = !packing && !rd_valid_i && !word_enq_o && !burst_enq_o &&
                         !word_full_i && !burst_full_i;

    always_ff @(posedge sdram_clk) begin
        if (sdram_rst) begin
            word_enq_o  <= 1'b0;
            burst_enq_o <= 1'b0;
            packing     <= 1'b0;
        end else begin
            word_enq_o  <= rd_valid_i && !rd_i.burst;
            burst_enq_o <= rd_valid_i && rd_i.burst && rd_i.last;
            if (rd_valid_i && rd_i.burst)
                packing <= !rd_i.last;
        end
    end

    always_ff @(posedge sdram_clk) begin
        if (rd_valid_i) begin
            word_d_o <= rd_i.data;
            if (rd_i.burst)
                pack <= {pack[1:`BURST_LEN-1], rd_i.data};  // Older words move up
        end
    end

    assign burst_d_o = pack;    // Complete in the cycle after the last word

endmodule

`default_nettype wire

//--- verilog/sdram_cmd_frontend.sv
/* Top level of the SDRAM command front end: command queue, decode, execute,
   result packing and the word and burst result queues, all on sdram_clk. */
`timescale 1ns/10ps
`default_nettype none
`include "sdram_cmd_cfg.svh"

module sdram_cmd_frontend (
    input  wire logic                    sdram_clk,
    input  wire logic                    sdram_rst,

    // Client commands
    input  wire sdram_cmd_pkg::cmd_t     cmd_i,
    input  wire logic                    cmd_enq_i,
    output logic                         cmd_full_o,
    output logic                         cmd_alm_full_o,

    // Single read results
    output sdram_cmd_pkg::word_t         word_q_o,
    input  wire logic                    word_deq_i,
    output logic                         word_empty_o,

    // Burst read results
    output sdram_cmd_pkg::burst_t        burst_q_o,
    input  wire logic                    burst_deq_i,
    output logic                         burst_empty_o,

    // Controller side
    output sdram_bus_pkg::wb_req_t       wb_o,
    input  wire sdram_bus_pkg::wb_rsp_t  wb_i
);
    import sdram_cmd_pkg::*;

    cmd_t     cmd_q;
    logic     cmd_empty;
    logic     cmd_deq;
    op_t      op;
    logic     op_valid;
    logic     op_ready;
    logic     res_ready;
    rd_word_t rd;
    logic     rd_valid;
    word_t    word_d;
    logic     word_enq;
    logic     word_full;
    burst_t   burst_d;
    logic     burst_enq;
    logic     burst_full;

    sync_fifo #(.payload_t(cmd_t), .DEPTH(`CMD_FIFO_DEPTH)) cmd_fifo_i (
        .sdram_clk, .sdram_rst,
        .d_i(cmd_i), .enq_i(cmd_enq_i), .full_o(cmd_full_o), .alm_full_o(cmd_alm_full_o),
        .q_o(cmd_q), .deq_i(cmd_deq), .empty_o(cmd_empty)
    );

    cmd_decode cmd_decode_i (
        .sdram_clk, .sdram_rst,
        .cmd_q_i(cmd_q), .cmd_empty_i(cmd_empty), .cmd_deq_o(cmd_deq),
        .op_o(op), .op_valid_o(op_valid), .op_ready_i(op_ready)
    );

    mem_execute mem_execute_i (
        .sdram_clk, .sdram_rst,
        .op_i(op), .op_valid_i(op_valid), .op_ready_o(op_ready),
        .res_ready_i(res_ready), .rd_o(rd), .rd_valid_o(rd_valid),
        .wb_o, .wb_i
    );

    read_result read_result_i (
        .sdram_clk, .sdram_rst,
        .rd_i(rd), .rd_valid_i(rd_valid), .res_ready_o(res_ready),
        .word_full_i(word_full), .burst_full_i(burst_full),
        .word_d_o(word_d), .word_enq_o(word_enq),
        .burst_d_o(burst_d), .burst_enq_o(burst_enq)
    );

    // Result queues, almost full unused on this side
    sync_fifo #(.payload_t(word_t), .DEPTH(`WORD_FIFO_DEPTH)) word_fifo_i (
        .sdram_clk, .sdram_rst,
        .d_i(word_d), .enq_i(word_enq), .full_o(word_full), .alm_full_o(),
        .q_o(word_q_o), .deq_i(word_deq_i), .empty_o(word_empty_o)
    );

    sync_fifo #(.payload_t(burst_t), .DEPTH(`BURST_FIFO_DEPTH)) burst_fifo_i (
        .sdram_clk, .sdram_rst,
        .d_i(burst_d), .enq_i(burst_enq), .full_o(burst_full), .alm_full_o(),
        .q_o(burst_q_o), .deq_i(burst_deq_i), .empty_o(burst_empty_o)
    );

endmodule

`default_nettype wire

//--- verif/sdram_cmd_properties.sv
/* Concurrent assertions on the Wishbone master port and the result queue flags.
   Bound into the front end top level from the testbench. */
`timescale 1ns/10ps
`default_nettype none

module sdram_cmd_properties (
    input  wire logic                   sdram_clk,
    input  wire logic                   sdram_rst,
    input  wire sdram_bus_pkg::wb_req_t wb_req_i,
    input  wire sdram_bus_pkg::wb_rsp_t wb_rsp_i,
    input  wire logic                   word_empty_i,
    input  wire logic                   burst_empty_i
);
    int fail_count = 0;     // Read by the testbench for its closing line

    stb_needs_cyc: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
        wb_req_i.stb |-> wb_req_i.cyc)
    else begin
        $error("Wishbone stb high without cyc");
        fail_count++;
    end

    // Transfer fields frozen until the slave answers
    fields_hold: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
        (wb_req_i.stb && !wb_rsp_i.ack) |=> $stable({wb_req_i.adr, wb_req_i.we, wb_req_i.dat}))
    else begin
        $error("Wishbone adr, we or dat changed while waiting for ack");
        fail_count++;
    end

    // Every transfer moves the whole word
    sel_both_bytes: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
        wb_req_i.stb |-> (wb_req_i.sel == 2'b11))
    else begin
        $error("Wishbone sel not set to both bytes during a transfer");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge sdram_clk)
        $fell(sdram_rst) |-> (word_empty_i && burst_empty_i && !wb_req_i.cyc))
    else begin
        $error("Queues not empty or cyc high right after reset");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- verif/sdram_cmd_checker.sv
/* Watches the front end ports, keeps a shadow memory and the expected results,
   and compares every dequeued result head against them. */
`timescale 1ns/10ps
`default_nettype none
`include "sdram_cmd_cfg.svh"

module sdram_cmd_checker (
    input  wire logic                   sdram_clk,
    input  wire logic                   sdram_rst,
    input  wire sdram_cmd_pkg::cmd_t    cmd_i,
    input  wire logic                   cmd_enq_i,
    input  wire logic                   cmd_full_i,
    input  wire logic                   cmd_alm_full_i,
    input  wire logic                   cmd_pop_i,
    input  wire sdram_cmd_pkg::word_t   word_q_i,
    input  wire logic                   word_deq_i,
    input  wire logic                   word_empty_i,
    input  wire sdram_cmd_pkg::burst_t  burst_q_i,
    input  wire logic                   burst_deq_i,
    input  wire logic                   burst_empty_i,
    output int                          error_count_o,
    output int                          pending_o
);
    import sdram_cmd_pkg::*;

    localparam int ALM_LEVEL = `CMD_FIFO_DEPTH - `FIFO_ALM_MARGIN;

    word_t  shadow [logic [23:0]];
    word_t  exp_words [$];
    burst_t exp_bursts [$];
    int     occ;                // Command queue occupancy

    function automatic word_t shadow_read(input logic [23:0] adr);
        if (shadow.exists(adr))
            return shadow[adr];
        return adr[15:0] ^ 16'h5a5a;
    endfunction

    // First word lands in slot 0, the top of the entry
    function automatic burst_t expected_burst(input logic [23:0] adr);
        burst_t b;
        for (int i = 0; i < `BURST_LEN; i++)
            b[i] = shadow_read(adr + 24'(i));
        return b;
    endfunction

    task automatic report_mismatch(input string what, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        error_count_o++;
    endtask

    always @(posedge sdram_clk) begin
        logic accept;
        logic pop;
        if (sdram_rst) begin
            occ = 0;
            exp_words.delete();
            exp_bursts.delete();
            error_count_o = 0;
        end else begin
            if ((occ == `CMD_FIFO_DEPTH) !== cmd_full_i)
                report_mismatch("cmd_full_o", 128'(cmd_full_i), 128'(occ == `CMD_FIFO_DEPTH));
            if ((occ >= ALM_LEVEL) !== cmd_alm_full_i)
                report_mismatch("cmd_alm_full_o", 128'(cmd_alm_full_i), 128'(occ >= ALM_LEVEL));
            if (word_deq_i && !word_empty_i) begin
                if (exp_words.size() == 0) begin
                    $display("** Error at time %0t: word result %h with no read pending",
                             $time, word_q_i);
                    error_count_o++;
                end else if (word_q_i !== exp_words[0]) begin
                    report_mismatch("word result", 128'(word_q_i), 128'(exp_words[0]));
                end
                if (exp_words.size() != 0)
                    exp_words.pop_front();
            end
            if (burst_deq_i && !burst_empty_i) begin
                if (exp_bursts.size() == 0) begin
                    $display("** Error at time %0t: burst result %h with no burst pending",
                             $time, burst_q_i);
                    error_count_o++;
                end else if (burst_q_i !== exp_bursts[0]) begin
                    report_mismatch("burst result", burst_q_i, exp_bursts[0]);
                end
                if (exp_bursts.size() != 0)
                    exp_bursts.pop_front();
            end
            // Commands take effect in enqueue order
            accept = cmd_enq_i && (occ < `CMD_FIFO_DEPTH);
            pop    = cmd_pop_i && (occ > 0);
            if (accept) begin
                if (cmd_i.we)
                    shadow[cmd_i.addr] = cmd_i.param;
                else if (cmd_i.param[0])
                    exp_bursts.push_back(expected_burst(cmd_i.addr));
                else
                    exp_words.push_back(shadow_read(cmd_i.addr));
            end
            if (accept && !pop)
                occ = occ + 1;
            else if (pop && !accept)
                occ = occ - 1;
        end
        pending_o = exp_words.size() + exp_bursts.size();
    end

endmodule

`default_nettype wire

//--- verif/sdram_cmd_tb.sv
/* Testbench for the SDRAM command front end. Sends random commands, plays the
   Wishbone memory slave with random wait states and prints the closing verdict. */
`timescale 1ns/10ps
`default_nettype none

module sdram_cmd_tb;
    import sdram_cmd_pkg::*;
    import sdram_bus_pkg::*;

    localparam int          NUM_CMDS    = 600;
    localparam logic [31:0] SEED        = 32'h79a1ffa0;
    localparam int          WATCHDOG_NS = NUM_CMDS * 40 * 20;

    logic    sdram_clk;
    logic    sdram_rst;
    cmd_t    cmd;
    logic    cmd_enq;
    logic    cmd_full;
    logic    cmd_alm_full;
    word_t   word_q;
    logic    word_deq;
    logic    word_empty;
    burst_t  burst_q;
    logic    burst_deq;
    logic    burst_empty;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    drain;            // Dequeue every cycle once stimulus is over
    int      checker_errors;
    int      pending;
    int      drain_errors;
    int      assert_fails;

    word_t slave_mem [logic [23:0]];

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Unwritten words read as a pattern of their address
    function automatic word_t slave_read(input logic [23:0] adr);
        if (slave_mem.exists(adr))
            return slave_mem[adr];
        return adr[15:0] ^ 16'h5a5a;
    endfunction

    task automatic send_cmd(input cmd_t c);
        @(posedge sdram_clk);
        #2;
        cmd     = c;
        cmd_enq = 1'b1;
        @(posedge sdram_clk);
        #2;
        cmd_enq = 1'b0;
    endtask

    sdram_cmd_frontend sdram_cmd_frontend_i (
        .sdram_clk, .sdram_rst,
        .cmd_i(cmd), .cmd_enq_i(cmd_enq), .cmd_full_o(cmd_full), .cmd_alm_full_o(cmd_alm_full),
        .word_q_o(word_q), .word_deq_i(word_deq), .word_empty_o(word_empty),
        .burst_q_o(burst_q), .burst_deq_i(burst_deq), .burst_empty_o(burst_empty),
        .wb_o(wb_req), .wb_i(wb_rsp)
    );

    sdram_cmd_checker checker_i (
        .sdram_clk, .sdram_rst,
        .cmd_i(cmd), .cmd_enq_i(cmd_enq), .cmd_full_i(cmd_full), .cmd_alm_full_i(cmd_alm_full),
        .cmd_pop_i(sdram_cmd_frontend_i.cmd_deq),
        .word_q_i(word_q), .word_deq_i(word_deq), .word_empty_i(word_empty),
        .burst_q_i(burst_q), .burst_deq_i(burst_deq), .burst_empty_i(burst_empty),
        .error_count_o(checker_errors), .pending_o(pending)
    );

    bind sdram_cmd_frontend sdram_cmd_properties properties_i (
        .sdram_clk, .sdram_rst,
        .wb_req_i(wb_o), .wb_rsp_i(wb_i),
        .word_empty_i(word_empty_o), .burst_empty_i(burst_empty_o)
    );

    initial begin
        sdram_clk = 1'b0;
        forever #10 sdram_clk = ~sdram_clk;
    end

    initial begin
        logic [31:0] rng;
        cmd_t        c;
        rng          = SEED;
        sdram_rst    = 1'b1;
        cmd          = '0;
        cmd_enq      = 1'b0;
        drain        = 1'b0;
        drain_errors = 0;
        repeat (4) @(posedge sdram_clk);
        #2 sdram_rst = 1'b0;
        for (int n = 0; n < NUM_CMDS; n++) begin
            rng = xorshift32(rng);
            repeat (int'(rng[27:24])) @(posedge sdram_clk);   // Enqueue gap
            c.we    = rng[0];
            c.addr  = 24'hfffff0 + 24'(rng[8:4]);   // Window wraps through zero
            c.param = rng[31:16];                   // Bit 0 picks burst on reads
            send_cmd(c);
        end
        drain = 1'b1;
        wait (pending == 0);
        repeat (20) @(posedge sdram_clk);
        #2;
        if (!word_empty || !burst_empty) begin
            drain_errors++;
            $display("Result queues still hold entries after full draining");
        end
        assert_fails = sdram_cmd_frontend_i.properties_i.fail_count;
        $display("Error counts: checker %0d, assertions %0d, drain %0d",
                 checker_errors, assert_fails, drain_errors);
        if (checker_errors + assert_fails + drain_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Result dequeues, with holds long enough to fill the command queue
    initial begin
        logic [31:0] rng;
        int          hold;
        rng       = SEED ^ 32'h3c3cc3c3;
        hold      = 0;
        word_deq  = 1'b0;
        burst_deq = 1'b0;
        @(negedge sdram_rst);
        forever begin
            @(posedge sdram_clk);
            #2;
            rng = xorshift32(rng);
            if (drain) begin
                word_deq  = 1'b1;
                burst_deq = 1'b1;
            end else if (hold > 0) begin
                hold--;
                word_deq  = 1'b0;
                burst_deq = 1'b0;
            end else begin
                if (rng[6:0] == 7'd0)
                    hold = 512 + int'(rng[13:8]);
                word_deq  = rng[16] | rng[17];
                burst_deq = rng[18] | rng[19];
            end
        end
    end

    // Wishbone slave, 0 to 3 wait cycles per transfer
    initial begin
        logic [31:0] rng;
        int          wait_left;
        rng       = ~SEED;
        wait_left = -1;
        wb_rsp    = '0;
        forever begin
            @(posedge sdram_clk);
            #2;
            wb_rsp = '0;
            if (wb_req.cyc && wb_req.stb) begin
                if (wait_left < 0) begin
                    rng       = xorshift32(rng);
                    wait_left = int'(rng[1:0]);
                end
                if (wait_left == 0) begin
                    wb_rsp.ack = 1'b1;
                    if (wb_req.we)
                        slave_mem[wb_req.adr] = wb_req.dat;
                    else
                        wb_rsp.dat = slave_read(wb_req.adr);
                    wait_left = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/sync_fifo.sv
verilog/sdram_cmd_pkg.sv
verilog/sdram_bus_pkg.sv
verilog/cmd_decode.sv
verilog/mem_execute.sv
verilog/read_result.sv
verilog/sdram_cmd_frontend.sv
verif/sdram_cmd_properties.sv
verif/sdram_cmd_checker.sv
verif/sdram_cmd_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compiles the front end testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module sdram_cmd_tb -Mdir obj_dir -o sdram_cmd_sim -f tb.f

status=0
./obj_dir/sdram_cmd_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "Run failed, see sim.log"
    exit 1
fi
grep -q "SIMULATION PASSED" sim.log
